//--- src/id_serialize_pkg.sv
// Shared definitions for the read ID serializer
// Port widths, slot count, per-slot depth and channel field types

`default_nettype none

package id_serialize_pkg;

  // ID widths at the two ports
  localparam int unsigned SlvIdWidth   = 6;
  localparam int unsigned MstIdWidth   = 2;

  // One slot per master ID
  localparam int unsigned NumSlots     = 4;
  localparam int unsigned SlotIdxWidth = 2;

  // Reads one slot may hold in flight
  localparam int unsigned MaxTxnsPerId = 4;

  localparam int unsigned AddrWidth    = 16;
  localparam int unsigned DataWidth    = 32;
  // A burst has len plus one beats
  localparam int unsigned LenWidth     = 4;

  typedef logic [SlvIdWidth-1:0]   slv_id_t;
  typedef logic [MstIdWidth-1:0]   mst_id_t;
  typedef logic [SlotIdxWidth-1:0] slot_idx_t;
  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [LenWidth-1:0]     len_t;

endpackage

`default_nettype wire

//--- src/id_fifo.sv
// Small circular-buffer FIFO
// Payload type and depth are parameters, head entry is shown while not empty

`timescale 1ns/100ps
`default_nettype none

module id_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 4
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     full_o,
  output logic     empty_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  payload_t            mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push_ok;
  logic                pop_ok;

  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CntWidth'(Depth));
  assign empty_o = (count_q == '0);
  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_ok) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Simultaneous push and pop leaves the fill level unchanged
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- src/id_serializer.sv
// Per-slot read serializer
// Drops the ID on AR and keeps it in order, restores it on the R burst

`timescale 1ns/100ps
`default_nettype none

module id_serializer import id_serialize_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  // Slave side, full IDs
  input  logic    in_ar_valid_i,
  output logic    in_ar_ready_o,
  input  slv_id_t in_ar_id_i,
  input  addr_t   in_ar_addr_i,
  input  len_t    in_ar_len_i,
  output logic    in_r_valid_o,
  input  logic    in_r_ready_i,
  output slv_id_t in_r_id_o,
  output data_t   in_r_data_o,
  output logic    in_r_last_o,
  // Master side, all transactions share one ID
  output logic    out_ar_valid_o,
  input  logic    out_ar_ready_i,
  output addr_t   out_ar_addr_o,
  output len_t    out_ar_len_o,
  input  logic    out_r_valid_i,
  output logic    out_r_ready_o,
  input  data_t   out_r_data_i,
  input  logic    out_r_last_i
);

  logic    id_full;
  logic    id_empty;
  logic    id_push;
  logic    id_pop;
  slv_id_t id_head;

  // New reads wait while the slot already holds MaxTxnsPerId bursts
  assign out_ar_valid_o = in_ar_valid_i & ~id_full;
  assign in_ar_ready_o  = out_ar_ready_i & ~id_full;
  assign out_ar_addr_o  = in_ar_addr_i;
  assign out_ar_len_o   = in_ar_len_i;
  assign id_push        = in_ar_valid_i & in_ar_ready_o;

  // Single downstream ID means bursts return in request order,
  // so the FIFO head always belongs to the burst in progress
  assign in_r_valid_o  = out_r_valid_i & ~id_empty;
  assign out_r_ready_o = in_r_ready_i & ~id_empty;
  assign in_r_id_o     = id_head;
  assign in_r_data_o   = out_r_data_i;
  assign in_r_last_o   = out_r_last_i;
  assign id_pop        = in_r_valid_o & in_r_ready_i & out_r_last_i;

  id_fifo #(
    .payload_t ( slv_id_t     ),
    .Depth     ( MaxTxnsPerId )
  ) i_id_fifo (
    .clk_i,
    .arst_n_i,
    .push_i  ( id_push    ),
    .data_i  ( in_ar_id_i ),
    .pop_i   ( id_pop     ),
    .data_o  ( id_head    ),
    .full_o  ( id_full    ),
    .empty_o ( id_empty   )
  );

endmodule

`default_nettype wire

//--- src/slot_demux.sv
// Slave-port demultiplexer
// Steers AR to a slot by ID modulo slot count and merges the slot
// R bursts back onto the slave port, one whole burst at a time

`timescale 1ns/100ps
`default_nettype none

module slot_demux import id_serialize_pkg::*; (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // Slave port
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  input  slv_id_t                ar_id_i,
  input  addr_t                  ar_addr_i,
  input  len_t                   ar_len_i,
  output logic                   r_valid_o,
  input  logic                   r_ready_i,
  output slv_id_t                r_id_o,
  output data_t                  r_data_o,
  output logic                   r_last_o,
  // Slot side
  output logic    [NumSlots-1:0] slot_ar_valid_o,
  input  logic    [NumSlots-1:0] slot_ar_ready_i,
  output slv_id_t [NumSlots-1:0] slot_ar_id_o,
  output addr_t   [NumSlots-1:0] slot_ar_addr_o,
  output len_t    [NumSlots-1:0] slot_ar_len_o,
  input  logic    [NumSlots-1:0] slot_r_valid_i,
  output logic    [NumSlots-1:0] slot_r_ready_o,
  input  slv_id_t [NumSlots-1:0] slot_r_id_i,
  input  data_t   [NumSlots-1:0] slot_r_data_i,
  input  logic    [NumSlots-1:0] slot_r_last_i
);

  slot_idx_t ar_sel;
  slot_idx_t rr_ptr_q;
  logic      locked_q;
  slot_idx_t lock_idx_q;
  slot_idx_t arb_idx;
  logic      arb_found;
  slot_idx_t r_sel;
  logic      r_xfer;

  // Low ID bits pick the slot
  assign ar_sel         = slot_idx_t'(ar_id_i[SlotIdxWidth-1:0]);
  assign ar_ready_o     = slot_ar_ready_i[ar_sel];
  assign slot_ar_id_o   = {NumSlots{ar_id_i}};
  assign slot_ar_addr_o = {NumSlots{ar_addr_i}};
  assign slot_ar_len_o  = {NumSlots{ar_len_i}};

  always_comb begin
    for (int unsigned i = 0; i < NumSlots; i++) begin
      slot_ar_valid_o[i] = ar_valid_i && (ar_sel == slot_idx_t'(i));
    end
  end

  // Round robin starting after the slot that finished the last burst
  always_comb begin
    slot_idx_t cand;
    cand      = rr_ptr_q;
    arb_idx   = rr_ptr_q;
    arb_found = 1'b0;
    for (int unsigned k = 1; k <= NumSlots; k++) begin
      cand = slot_idx_t'(rr_ptr_q + k);
      if (!arb_found && slot_r_valid_i[cand]) begin
        arb_idx   = cand;
        arb_found = 1'b1;
      end
    end
  end

  // Once a slot is shown it keeps the port until its last beat
  assign r_sel     = locked_q ? lock_idx_q : arb_idx;
  assign r_valid_o = locked_q ? slot_r_valid_i[lock_idx_q] : arb_found;
  assign r_id_o    = slot_r_id_i[r_sel];
  assign r_data_o  = slot_r_data_i[r_sel];
  assign r_last_o  = slot_r_last_i[r_sel];
  assign r_xfer    = r_valid_o & r_ready_i;

  always_comb begin
    for (int unsigned i = 0; i < NumSlots; i++) begin
      slot_r_ready_o[i] = r_ready_i && (r_sel == slot_idx_t'(i));
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q   <= '0;
      locked_q   <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      if (r_xfer && r_last_o) begin
        locked_q <= 1'b0;
        rr_ptr_q <= r_sel;
      end else if (r_valid_o && !locked_q) begin
        locked_q   <= 1'b1;
        lock_idx_q <= r_sel;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/slot_mux.sv
// Master-port multiplexer
// Round-robin AR arbitration over the slots with the slot index as
// master ID, R beats routed back to the slot named by their ID

`timescale 1ns/100ps
`default_nettype none

module slot_mux import id_serialize_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Slot side
  input  logic   [NumSlots-1:0] slot_ar_valid_i,
  output logic   [NumSlots-1:0] slot_ar_ready_o,
  input  addr_t  [NumSlots-1:0] slot_ar_addr_i,
  input  len_t   [NumSlots-1:0] slot_ar_len_i,
  output logic   [NumSlots-1:0] slot_r_valid_o,
  input  logic   [NumSlots-1:0] slot_r_ready_i,
  output data_t  [NumSlots-1:0] slot_r_data_o,
  output logic   [NumSlots-1:0] slot_r_last_o,
  // Master port
  output logic                  mst_ar_valid_o,
  input  logic                  mst_ar_ready_i,
  output mst_id_t               mst_ar_id_o,
  output addr_t                 mst_ar_addr_o,
  output len_t                  mst_ar_len_o,
  input  logic                  mst_r_valid_i,
  output logic                  mst_r_ready_o,
  input  mst_id_t               mst_r_id_i,
  input  data_t                 mst_r_data_i,
  input  logic                  mst_r_last_i
);

  slot_idx_t rr_ptr_q;
  slot_idx_t ar_idx;
  logic      ar_found;
  slot_idx_t r_idx;

  // First valid slot after the last winner
  always_comb begin
    slot_idx_t cand;
    cand     = rr_ptr_q;
    ar_idx   = rr_ptr_q;
    ar_found = 1'b0;
    for (int unsigned k = 1; k <= NumSlots; k++) begin
      cand = slot_idx_t'(rr_ptr_q + k);
      if (!ar_found && slot_ar_valid_i[cand]) begin
        ar_idx   = cand;
        ar_found = 1'b1;
      end
    end
  end

  assign mst_ar_valid_o = ar_found;
  assign mst_ar_id_o    = mst_id_t'(ar_idx);
  assign mst_ar_addr_o  = slot_ar_addr_i[ar_idx];
  assign mst_ar_len_o   = slot_ar_len_i[ar_idx];

  always_comb begin
    for (int unsigned i = 0; i < NumSlots; i++) begin
      slot_ar_ready_o[i] = mst_ar_ready_i && (ar_idx == slot_idx_t'(i));
    end
  end

  // Pointer only moves on a transfer
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q <= '0;
    end else if (mst_ar_valid_o && mst_ar_ready_i) begin
      rr_ptr_q <= ar_idx;
    end
  end

  // Master ID is the slot index
  assign r_idx         = slot_idx_t'(mst_r_id_i);
  assign mst_r_ready_o = slot_r_ready_i[r_idx];
  assign slot_r_data_o = {NumSlots{mst_r_data_i}};
  assign slot_r_last_o = {NumSlots{mst_r_last_i}};

  always_comb begin
    for (int unsigned i = 0; i < NumSlots; i++) begin
      slot_r_valid_o[i] = mst_r_valid_i && (r_idx == slot_idx_t'(i));
    end
  end

endmodule

`default_nettype wire

//--- src/id_serialize_top.sv
// Read ID serializer top level
// Maps a 6-bit slave-port ID space onto four master IDs through
// the slot demux, one serializer per slot and the slot mux

`timescale 1ns/100ps
`default_nettype none

module id_serialize_top import id_serialize_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  // Slave port
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  input  slv_id_t ar_id_i,
  input  addr_t   ar_addr_i,
  input  len_t    ar_len_i,
  output logic    r_valid_o,
  input  logic    r_ready_i,
  output slv_id_t r_id_o,
  output data_t   r_data_o,
  output logic    r_last_o,
  // Master port
  output logic    mst_ar_valid_o,
  input  logic    mst_ar_ready_i,
  output mst_id_t mst_ar_id_o,
  output addr_t   mst_ar_addr_o,
  output len_t    mst_ar_len_o,
  input  logic    mst_r_valid_i,
  output logic    mst_r_ready_o,
  input  mst_id_t mst_r_id_i,
  input  data_t   mst_r_data_i,
  input  logic    mst_r_last_i
);

  // Demux to serializers
  logic    [NumSlots-1:0] dmx_ar_valid;
  logic    [NumSlots-1:0] dmx_ar_ready;
  slv_id_t [NumSlots-1:0] dmx_ar_id;
  addr_t   [NumSlots-1:0] dmx_ar_addr;
  len_t    [NumSlots-1:0] dmx_ar_len;
  logic    [NumSlots-1:0] dmx_r_valid;
  logic    [NumSlots-1:0] dmx_r_ready;
  slv_id_t [NumSlots-1:0] dmx_r_id;
  data_t   [NumSlots-1:0] dmx_r_data;
  logic    [NumSlots-1:0] dmx_r_last;

  // Serializers to mux
  logic    [NumSlots-1:0] ser_ar_valid;
  logic    [NumSlots-1:0] ser_ar_ready;
  addr_t   [NumSlots-1:0] ser_ar_addr;
  len_t    [NumSlots-1:0] ser_ar_len;
  logic    [NumSlots-1:0] ser_r_valid;
  logic    [NumSlots-1:0] ser_r_ready;
  data_t   [NumSlots-1:0] ser_r_data;
  logic    [NumSlots-1:0] ser_r_last;

  slot_demux i_slot_demux (
    .clk_i,
    .arst_n_i,
    .ar_valid_i,
    .ar_ready_o,
    .ar_id_i,
    .ar_addr_i,
    .ar_len_i,
    .r_valid_o,
    .r_ready_i,
    .r_id_o,
    .r_data_o,
    .r_last_o,
    .slot_ar_valid_o ( dmx_ar_valid ),
    .slot_ar_ready_i ( dmx_ar_ready ),
    .slot_ar_id_o    ( dmx_ar_id    ),
    .slot_ar_addr_o  ( dmx_ar_addr  ),
    .slot_ar_len_o   ( dmx_ar_len   ),
    .slot_r_valid_i  ( dmx_r_valid  ),
    .slot_r_ready_o  ( dmx_r_ready  ),
    .slot_r_id_i     ( dmx_r_id     ),
    .slot_r_data_i   ( dmx_r_data   ),
    .slot_r_last_i   ( dmx_r_last   )
  );

  for (genvar i = 0; i < NumSlots; i++) begin : gen_serializers
    id_serializer i_id_serializer (
      .clk_i,
      .arst_n_i,
      .in_ar_valid_i  ( dmx_ar_valid[i] ),
      .in_ar_ready_o  ( dmx_ar_ready[i] ),
      .in_ar_id_i     ( dmx_ar_id[i]    ),
      .in_ar_addr_i   ( dmx_ar_addr[i]  ),
      .in_ar_len_i    ( dmx_ar_len[i]   ),
      .in_r_valid_o   ( dmx_r_valid[i]  ),
      .in_r_ready_i   ( dmx_r_ready[i]  ),
      .in_r_id_o      ( dmx_r_id[i]     ),
      .in_r_data_o    ( dmx_r_data[i]   ),
      .in_r_last_o    ( dmx_r_last[i]   ),
      .out_ar_valid_o ( ser_ar_valid[i] ),
      .out_ar_ready_i ( ser_ar_ready[i] ),
      .out_ar_addr_o  ( ser_ar_addr[i]  ),
      .out_ar_len_o   ( ser_ar_len[i]   ),
      .out_r_valid_i  ( ser_r_valid[i]  ),
      .out_r_ready_o  ( ser_r_ready[i]  ),
      .out_r_data_i   ( ser_r_data[i]   ),
      .out_r_last_i   ( ser_r_last[i]   )
    );
  end

  slot_mux i_slot_mux (
    .clk_i,
    .arst_n_i,
    .slot_ar_valid_i ( ser_ar_valid ),
    .slot_ar_ready_o ( ser_ar_ready ),
    .slot_ar_addr_i  ( ser_ar_addr  ),
    .slot_ar_len_i   ( ser_ar_len   ),
    .slot_r_valid_o  ( ser_r_valid  ),
    .slot_r_ready_i  ( ser_r_ready  ),
    .slot_r_data_o   ( ser_r_data   ),
    .slot_r_last_o   ( ser_r_last   ),
    .mst_ar_valid_o,
    .mst_ar_ready_i,
    .mst_ar_id_o,
    .mst_ar_addr_o,
    .mst_ar_len_o,
    .mst_r_valid_i,
    .mst_r_ready_o,
    .mst_r_id_i,
    .mst_r_data_i,
    .mst_r_last_i
  );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// Testbench clock and reset source
// Free-running clock and an active-low reset held for a number of cycles

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int PeriodNs    = 40,
  parameter int ResetCycles = 16
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release falls between two edges
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #(PeriodNs / 4);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/tb_id_serialize.sv
// Testbench for the read ID serializer
// Reads requests from a pattern file, answers them with a memory model on
// the master port and checks IDs, data, ordering and burst integrity

`timescale 1ns/100ps
`default_nettype none

module tb_id_serialize import id_serialize_pkg::*; ();

  localparam int ClkPeriodNs = 40;
  localparam int MaxPats     = 64;
  localparam int QDepth      = 8;

  logic    clk;
  logic    arst_n;
  logic    ar_valid;
  logic    ar_ready;
  slv_id_t ar_id;
  addr_t   ar_addr;
  len_t    ar_len;
  logic    r_valid;
  logic    r_ready;
  slv_id_t r_id;
  data_t   r_data;
  logic    r_last;
  logic    mst_ar_valid;
  logic    mst_ar_ready;
  mst_id_t mst_ar_id;
  addr_t   mst_ar_addr;
  len_t    mst_ar_len;
  logic    mst_r_valid;
  logic    mst_r_ready;
  mst_id_t mst_r_id;
  data_t   mst_r_data;
  logic    mst_r_last;

  // Five words per read: test, id, addr, len, expected master ID
  logic [31:0] pat_mem [1 + 5 * MaxPats];
  int          num_pats    = 0;
  int          total_beats = 0;

  // Expected reads per slot in slave-port order
  slv_id_t sb_id   [NumSlots][QDepth];
  addr_t   sb_addr [NumSlots][QDepth];
  len_t    sb_len  [NumSlots][QDepth];
  int      sb_wr   [NumSlots];
  int      sb_rd   [NumSlots];

  // Responder queues per master ID
  addr_t   rsp_addr [NumSlots][QDepth];
  len_t    rsp_len  [NumSlots][QDepth];
  int      rsp_wr   [NumSlots];
  int      rsp_rd   [NumSlots];

  mst_id_t cur_exp_mst;
  logic    hold_resp;
  logic    stall_seen;
  bit      in_burst     = 1'b0;
  int      burst_slot   = 0;
  int      beat_idx     = 0;
  int      beats_seen   = 0;
  int      bursts_done  = 0;
  int      err_count    = 0;
  int      tests_run    = 0;
  int      tests_failed = 0;

  tb_clock_gen #(
    .PeriodNs    ( ClkPeriodNs ),
    .ResetCycles ( 16          )
  ) i_clock_gen (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  id_serialize_top i_id_serialize_top (
    .clk_i          ( clk          ),
    .arst_n_i       ( arst_n       ),
    .ar_valid_i     ( ar_valid     ),
    .ar_ready_o     ( ar_ready     ),
    .ar_id_i        ( ar_id        ),
    .ar_addr_i      ( ar_addr      ),
    .ar_len_i       ( ar_len       ),
    .r_valid_o      ( r_valid      ),
    .r_ready_i      ( r_ready      ),
    .r_id_o         ( r_id         ),
    .r_data_o       ( r_data       ),
    .r_last_o       ( r_last       ),
    .mst_ar_valid_o ( mst_ar_valid ),
    .mst_ar_ready_i ( mst_ar_ready ),
    .mst_ar_id_o    ( mst_ar_id    ),
    .mst_ar_addr_o  ( mst_ar_addr  ),
    .mst_ar_len_o   ( mst_ar_len   ),
    .mst_r_valid_i  ( mst_r_valid  ),
    .mst_r_ready_o  ( mst_r_ready  ),
    .mst_r_id_i     ( mst_r_id     ),
    .mst_r_data_i   ( mst_r_data   ),
    .mst_r_last_i   ( mst_r_last   )
  );

  function automatic logic [31:0] pat_field(input int n, input int f);
    return pat_mem[1 + 5 * n + f];
  endfunction

  function automatic int outstanding(input int slot);
    return sb_wr[slot] - sb_rd[slot];
  endfunction

  // Memory model data for beat k of a burst
  function automatic data_t beat_data(input addr_t addr, input int k);
    return {8'h00, addr, 8'h00} + data_t'(k);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Fail %0t: %s = %0h, expected %0h", $time, name, got, exp);
    err_count++;
  endtask

  task automatic note_failure(input string msg);
    $display("Error at %0t: %s", $time, msg);
    err_count++;
  endtask

  // Drive one read and hold it until the slave port takes it
  task automatic issue_read(input int n);
    int   slot;
    int   stall;
    logic accepted;
    slot        = pat_field(n, 1) & (NumSlots - 1);
    stall       = 0;
    accepted    = 1'b0;
    ar_valid    = 1'b1;
    ar_id       = slv_id_t'(pat_field(n, 1));
    ar_addr     = addr_t'(pat_field(n, 2));
    ar_len      = len_t'(pat_field(n, 3));
    cur_exp_mst = mst_id_t'(pat_field(n, 4));
    while (!accepted) begin
      @(negedge clk);
      accepted = ar_ready;
      @(posedge clk);
      #1;
      // A full slot must keep the request waiting while responses are held
      if (!accepted && hold_resp && outstanding(slot) == MaxTxnsPerId) begin
        stall++;
        if (stall == 8) begin
          stall_seen = 1'b1;
          hold_resp  = 1'b0;
        end
      end
    end
    ar_valid = 1'b0;
  endtask

  // Memory responder on the master port, whole bursts from a random queue
  initial begin : responder
    int    seed;
    logic  ar_hit;
    logic  r_hit;
    logic  held;
    int    hit_id;
    addr_t hit_addr;
    len_t  hit_len;
    logic  busy;
    int    cur;
    int    beat;
    int    pick;
    int    q;
    seed         = 32'h2065_2146;
    busy         = 1'b0;
    cur          = 0;
    beat         = 0;
    mst_ar_ready = 1'b0;
    mst_r_valid  = 1'b0;
    mst_r_id     = '0;
    mst_r_data   = '0;
    mst_r_last   = 1'b0;
    r_ready      = 1'b0;
    forever begin
      @(negedge clk);
      ar_hit   = mst_ar_valid && mst_ar_ready;
      r_hit    = mst_r_valid && mst_r_ready;
      held     = hold_resp;
      hit_id   = mst_ar_id;
      hit_addr = mst_ar_addr;
      hit_len  = mst_ar_len;
      @(posedge clk);
      #1;
      if (ar_hit) begin
        rsp_addr[hit_id][rsp_wr[hit_id] % QDepth] = hit_addr;
        rsp_len[hit_id][rsp_wr[hit_id] % QDepth]  = hit_len;
        rsp_wr[hit_id]++;
      end
      if (r_hit) begin
        if (mst_r_last) begin
          busy = 1'b0;
          rsp_rd[cur]++;
        end else begin
          beat++;
        end
      end
      if (!busy && !held) begin
        pick = $random(seed) & (NumSlots - 1);
        for (int k = 0; k < NumSlots; k++) begin
          q = (pick + k) % NumSlots;
          if (!busy && rsp_wr[q] != rsp_rd[q]) begin
            busy = 1'b1;
            cur  = q;
            beat = 0;
          end
        end
      end
      mst_r_valid = busy;
      mst_r_id    = mst_id_t'(cur);
      if (busy) begin
        mst_r_data = beat_data(rsp_addr[cur][rsp_rd[cur] % QDepth], beat);
        mst_r_last = (beat == int'(rsp_len[cur][rsp_rd[cur] % QDepth]));
      end else begin
        mst_r_data = '0;
        mst_r_last = 1'b0;
      end
      mst_ar_ready = ($random(seed) & 3) != 0;
      r_ready      = ($random(seed) & 3) != 0;
    end
  end

  // Handshakes are sampled mid-cycle, where all DUT outputs have settled
  always @(negedge clk) begin : monitor
    int    slot;
    int    head;
    data_t exp_data;
    if (arst_n) begin
      if (ar_valid && ar_ready) begin
        slot = ar_id[SlotIdxWidth-1:0];
        if (outstanding(slot) >= MaxTxnsPerId) begin
          note_failure("read accepted for a slot that already holds the maximum");
        end
        if (!(mst_ar_valid && mst_ar_ready)) begin
          note_failure("read accepted at the slave port but not sent to the master port");
        end else begin
          if (mst_ar_id !== cur_exp_mst) begin
            report_mismatch("mst_ar_id_o", mst_ar_id, cur_exp_mst);
          end
          if (mst_ar_addr !== ar_addr) begin
            report_mismatch("mst_ar_addr_o", mst_ar_addr, ar_addr);
          end
          if (mst_ar_len !== ar_len) begin
            report_mismatch("mst_ar_len_o", mst_ar_len, ar_len);
          end
        end
        sb_id[slot][sb_wr[slot] % QDepth]   = ar_id;
        sb_addr[slot][sb_wr[slot] % QDepth] = ar_addr;
        sb_len[slot][sb_wr[slot] % QDepth]  = ar_len;
        sb_wr[slot]++;
      end else if (mst_ar_valid && mst_ar_ready) begin
        note_failure("master port read without a slave port request");
      end

      if (r_valid && r_ready) begin
        slot = r_id[SlotIdxWidth-1:0];
        if (in_burst && slot != burst_slot) begin
          note_failure("read data beats of two bursts interleaved");
        end
        if (outstanding(slot) == 0) begin
          note_failure("read data beat with no outstanding read");
        end else begin
          head     = sb_rd[slot] % QDepth;
          exp_data = beat_data(sb_addr[slot][head], beat_idx);
          if (r_id !== sb_id[slot][head]) begin
            report_mismatch("r_id_o", r_id, sb_id[slot][head]);
          end
          if (r_data !== exp_data) begin
            report_mismatch("r_data_o", r_data, exp_data);
          end
          if (r_last !== (beat_idx == int'(sb_len[slot][head]))) begin
            report_mismatch("r_last_o", r_last, beat_idx == int'(sb_len[slot][head]));
          end
          beats_seen++;
          if (r_last) begin
            sb_rd[slot]++;
            bursts_done++;
            in_burst = 1'b0;
            beat_idx = 0;
          end else begin
            in_burst   = 1'b1;
            burst_slot = slot;
            beat_idx++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    wait (total_beats > 0);
    #(total_beats * 200 * ClkPeriodNs);
    $display("Timeout: the run did not finish within %0d clock cycles", total_beats * 200);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : main
    int   test_no;
    int   first;
    int   idx;
    int   issued;
    int   test_errs;
    int   test_beats;
    int   count [NumSlots];
    logic over_full;
    ar_valid    = 1'b0;
    ar_id       = '0;
    ar_addr     = '0;
    ar_len      = '0;
    cur_exp_mst = '0;
    hold_resp   = 1'b0;
    stall_seen  = 1'b0;
    $readmemh("verif/id_serialize_patterns.txt", pat_mem);
    if ($isunknown(pat_mem[0]) || pat_mem[0] == 0 || pat_mem[0] > MaxPats) begin
      note_failure("pattern file missing or malformed");
    end else begin
      num_pats = pat_mem[0];
    end
    for (int i = 0; i < num_pats; i++) begin
      total_beats += pat_field(i, 3) + 1;
    end

    wait (arst_n === 1'b1);
    @(posedge clk);
    #1;
    if (r_valid !== 1'b0) begin
      report_mismatch("r_valid_o", r_valid, 0);
    end
    if (mst_ar_valid !== 1'b0) begin
      report_mismatch("mst_ar_valid_o", mst_ar_valid, 0);
    end

    idx    = 0;
    issued = 0;
    while (idx < num_pats) begin
      test_no    = pat_field(idx, 0);
      first      = idx;
      test_errs  = err_count;
      test_beats = 0;
      over_full  = 1'b0;
      for (int s = 0; s < NumSlots; s++) begin
        count[s] = 0;
      end
      while (idx < num_pats && pat_field(idx, 0) == test_no) begin
        count[pat_field(idx, 1) & (NumSlots - 1)]++;
        idx++;
      end
      for (int s = 0; s < NumSlots; s++) begin
        if (count[s] > MaxTxnsPerId) begin
          over_full = 1'b1;
        end
      end
      // Responses wait so an over-full slot has to stall
      hold_resp  = over_full;
      stall_seen = 1'b0;
      for (int i = first; i < idx; i++) begin
        issue_read(i);
        test_beats += pat_field(i, 3) + 1;
        issued++;
      end
      hold_resp = 1'b0;
      while (bursts_done < issued) begin
        @(posedge clk);
      end
      @(posedge clk);
      #1;
      if (over_full && !stall_seen) begin
        note_failure("request to a full slot was not held back");
      end
      tests_run++;
      if (err_count != test_errs) begin
        tests_failed++;
      end
      $display("Test %0d: %0d reads, %0d beats, %s", test_no, idx - first, test_beats,
               (err_count == test_errs) ? "passed" : "failed");
    end

    if (beats_seen != total_beats) begin
      report_mismatch("slave port beat count", beats_seen, total_beats);
    end
    // Every burst the master port took must also have been fully delivered
    for (int s = 0; s < NumSlots; s++) begin
      if (rsp_wr[s] != rsp_rd[s]) begin
        note_failure($sformatf("responder still owes read data for master ID %0d", s));
      end
    end
    $display("Tests run %0d, tests failed %0d, beats checked %0d, errors %0d",
             tests_run, tests_failed, beats_seen, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/id_serialize_patterns.txt
// Columns in hex: test, slave ID, address, len, expected master ID
// The first word is the number of read lines that follow
16

1 00 0100 0 0
1 05 0110 1 1
1 0a 0120 2 2
1 0f 0130 3 3
1 11 0140 0 1
1 3e 0150 1 2

2 2b 1200 7 3
2 14 1300 5 0
2 39 1400 2 1

3 13 2000 3 3
3 13 2100 1 3
3 07 2200 2 3
3 23 2300 0 3

4 04 3000 f 0
4 19 3100 e 1
4 26 3200 d 2
4 3b 3300 c 3

5 02 4000 3 2
5 06 4100 2 2
5 0a 4200 1 2
5 0e 4300 0 2
5 22 4400 4 2

//--- all.f
src/id_serialize_pkg.sv
src/id_fifo.sv
src/id_serializer.sv
src/slot_demux.sv
src/slot_mux.sv
src/id_serialize_top.sv
verif/tb_clock_gen.sv
verif/tb_id_serialize.sv

//--- Bender.yml
package:
  name: id_serialize

sources:
  - src/id_serialize_pkg.sv
  - src/id_fifo.sv
  - src/id_serializer.sv
  - src/slot_demux.sv
  - src/slot_mux.sv
  - src/id_serialize_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_id_serialize.sv
